// File: Bender.yml
package:
  name: result_bus_core

sources:
  # design
  - hw/result_bus_pkg.sv
  - hw/int_alu.sv
  - hw/int_mul.sv
  - hw/bus_reservation.sv
  - hw/tag_allocator.sv
  - hw/result_bus_core.sv

  # testbench
  - target: simulation
    files:
      - verification/result_bus_checker.sv
      - verification/result_bus_core_tb.sv

// File: hw/bus_reservation.sv
module bus_reservation import result_bus_pkg::*; #(
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
	parameter int TAG_WIDTH = DEFAULT_TAG_WIDTH,
	parameter int MUL_LATENCY = DEFAULT_MUL_LATENCY
) (
	input logic clk,
	input logic rst,

	// issue side
	input logic issue_valid,
	input op_t issue_op,
	input logic tag_free,
	output logic issue_ready,
	output logic issue_fire,
	output logic alu_start,
	output logic mul_start,

	// unit returns
	input logic alu_valid,
	input logic[TAG_WIDTH-1:0] alu_tag,
	input logic[DATA_WIDTH-1:0] alu_result,
	input logic mul_valid,
	input logic[TAG_WIDTH-1:0] mul_tag,
	input logic[DATA_WIDTH-1:0] mul_result,

	// result bus
	output logic cdb_valid,
	output logic[TAG_WIDTH-1:0] cdb_tag,
	output logic[DATA_WIDTH-1:0] cdb_data
);
	// a multiply lands MUL_LATENCY-1 shifts after booking
	localparam int N_SLOTS = MUL_LATENCY - 1;

	// slot 0 is the landing position, slot N_SLOTS-1 the far end
	logic[N_SLOTS-1:0] slot_valid;
	unit_t slot_unit[N_SLOTS];

	// slot that left position 0 and owns the bus this cycle
	logic retire_valid;
	unit_t retire_unit;

	logic alu_op;
	logic landing_busy;
	logic mul_sel;

	//////////////////////////////
	// issue gating
	//////////////////////////////

	assign alu_op = issue_op != OP_MUL;

	// an alu op issued now would share the bus cycle of slot 0
	assign landing_busy = slot_valid[0];

	// multiplies never collide, each books its own far end slot
	assign issue_ready = tag_free && !(alu_op && landing_busy);
	assign issue_fire = issue_valid && issue_ready;
	assign alu_start = issue_fire && alu_op;
	assign mul_start = issue_fire && !alu_op;

	//////////////////////////////
	// slot shift register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_valid <= '0;
			for (int i = 0; i < N_SLOTS; i++) begin
				slot_unit[i] <= UNIT_ALU;
			end
			retire_valid <= 1'b0;
			retire_unit <= UNIT_ALU;
		end else begin
			for (int i = 0; i < N_SLOTS - 1; i++) begin
				slot_valid[i] <= slot_valid[i+1];
				slot_unit[i] <= slot_unit[i+1];
			end
			// booking at the far end
			slot_valid[N_SLOTS-1] <= mul_start;
			slot_unit[N_SLOTS-1] <= mul_start ? UNIT_MUL : UNIT_ALU;
			retire_valid <= slot_valid[0];
			retire_unit <= slot_unit[0];
		end
	end

	//////////////////////////////
	// result bus select
	//////////////////////////////

	// booked slot wins the bus, otherwise the alu result if any
	assign mul_sel = retire_valid && retire_unit == UNIT_MUL;

	assign cdb_valid = mul_sel ? mul_valid : alu_valid;
	assign cdb_tag = mul_sel ? mul_tag : alu_tag;
	assign cdb_data = mul_sel ? mul_result : alu_result;
endmodule

// File: hw/int_alu.sv
module int_alu import result_bus_pkg::*; #(
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
	parameter int TAG_WIDTH = DEFAULT_TAG_WIDTH
) (
	input logic clk,
	input logic rst,
	input logic start,
	input op_t op,
	input logic[DATA_WIDTH-1:0] a,
	input logic[DATA_WIDTH-1:0] b,
	input logic[TAG_WIDTH-1:0] tag_in,
	output logic valid,
	output logic[TAG_WIDTH-1:0] tag,
	output logic[DATA_WIDTH-1:0] result
);
	logic[DATA_WIDTH-1:0] alu_out;

	// add and sub wrap at DATA_WIDTH
	always_comb begin
		case (op)
			OP_ADD: alu_out = a + b;
			OP_SUB: alu_out = a - b;
			OP_AND: alu_out = a & b;
			OP_XOR: alu_out = a ^ b;
			default: alu_out = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= start;
		end
	end

	// result and tag only move on a start
	always_ff @(posedge clk) begin
		if (start) begin
			tag <= tag_in;
			result <= alu_out;
		end
	end
endmodule

// File: hw/int_mul.sv
module int_mul import result_bus_pkg::*; #(
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
	parameter int TAG_WIDTH = DEFAULT_TAG_WIDTH,
	parameter int MUL_LATENCY = DEFAULT_MUL_LATENCY
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic[DATA_WIDTH-1:0] a,
	input logic[DATA_WIDTH-1:0] b,
	input logic[TAG_WIDTH-1:0] tag_in,
	output logic valid,
	output logic[TAG_WIDTH-1:0] tag,
	output logic[DATA_WIDTH-1:0] result
);
	// stage 0 is loaded on start, the last stage drives the outputs
	logic[MUL_LATENCY-1:0] stage_valid;
	logic[TAG_WIDTH-1:0] stage_tag[MUL_LATENCY];
	logic[DATA_WIDTH-1:0] stage_prod[MUL_LATENCY];
	logic[DATA_WIDTH-1:0] product;

	//////////////////////////////
	// multiply
	//////////////////////////////

	// low half of the unsigned product
	// registers behind it get retimed into the array
	assign product = a * b;

	//////////////////////////////
	// pipeline
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			stage_valid <= '0;
		end else begin
			stage_valid <= {stage_valid[MUL_LATENCY-2:0], start};
		end
	end

	// tag rides along with its product
	always_ff @(posedge clk) begin
		stage_tag[0] <= tag_in;
		stage_prod[0] <= product;
		for (int i = 1; i < MUL_LATENCY; i++) begin
			stage_tag[i] <= stage_tag[i-1];
			stage_prod[i] <= stage_prod[i-1];
		end
	end

	assign valid = stage_valid[MUL_LATENCY-1];
	assign tag = stage_tag[MUL_LATENCY-1];
	assign result = stage_prod[MUL_LATENCY-1];
endmodule

// File: hw/result_bus_core.sv
module result_bus_core import result_bus_pkg::*; #(
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
	parameter int TAG_WIDTH = DEFAULT_TAG_WIDTH,
	parameter int MUL_LATENCY = DEFAULT_MUL_LATENCY
) (
	input logic clk,
	input logic rst,

	// issue port
	input logic issue_valid,
	input op_t issue_op,
	input logic[DATA_WIDTH-1:0] issue_a,
	input logic[DATA_WIDTH-1:0] issue_b,
	output logic issue_ready,
	output logic[TAG_WIDTH-1:0] issue_tag,

	// result bus
	output logic cdb_valid,
	output logic[TAG_WIDTH-1:0] cdb_tag,
	output logic[DATA_WIDTH-1:0] cdb_data,

	output logic idle
);
	//////////////////////////////
	// wires
	//////////////////////////////

	logic tag_free;
	logic issue_fire;
	logic alu_start;
	logic mul_start;

	logic alu_valid;
	logic[TAG_WIDTH-1:0] alu_tag;
	logic[DATA_WIDTH-1:0] alu_result;

	logic mul_valid;
	logic[TAG_WIDTH-1:0] mul_tag;
	logic[DATA_WIDTH-1:0] mul_result;

	//////////////////////////////
	// units
	//////////////////////////////

	int_alu #(
		.DATA_WIDTH(DATA_WIDTH),
		.TAG_WIDTH(TAG_WIDTH)
	) u_alu (
		.clk,
		.rst,
		.start(alu_start),
		.op(issue_op),
		.a(issue_a),
		.b(issue_b),
		.tag_in(issue_tag),
		.valid(alu_valid),
		.tag(alu_tag),
		.result(alu_result)
	);

	int_mul #(
		.DATA_WIDTH(DATA_WIDTH),
		.TAG_WIDTH(TAG_WIDTH),
		.MUL_LATENCY(MUL_LATENCY)
	) u_mul (
		.clk,
		.rst,
		.start(mul_start),
		.a(issue_a),
		.b(issue_b),
		.tag_in(issue_tag),
		.valid(mul_valid),
		.tag(mul_tag),
		.result(mul_result)
	);

	//////////////////////////////
	// control
	//////////////////////////////

	// every broadcast result gives its tag back
	tag_allocator #(
		.TAG_WIDTH(TAG_WIDTH)
	) u_tag_allocator (
		.clk,
		.rst,
		.alloc(issue_fire),
		.retire(cdb_valid),
		.next_tag(issue_tag),
		.tag_free,
		.idle
	);

	bus_reservation #(
		.DATA_WIDTH(DATA_WIDTH),
		.TAG_WIDTH(TAG_WIDTH),
		.MUL_LATENCY(MUL_LATENCY)
	) u_reservation (
		.clk,
		.rst,
		.issue_valid,
		.issue_op,
		.tag_free,
		.issue_ready,
		.issue_fire,
		.alu_start,
		.mul_start,
		.alu_valid,
		.alu_tag,
		.alu_result,
		.mul_valid,
		.mul_tag,
		.mul_result,
		.cdb_valid,
		.cdb_tag,
		.cdb_data
	);
endmodule

// File: hw/result_bus_pkg.sv
package result_bus_pkg;

	//////////////////////////////
	// default sizes
	//////////////////////////////

	// operand and result width
	localparam int DEFAULT_DATA_WIDTH = 32;

	// 2 bits gives 4 tags in flight
	localparam int DEFAULT_TAG_WIDTH = 2;

	// multiplier pipeline depth, at least 2
	localparam int DEFAULT_MUL_LATENCY = 4;

	//////////////////////////////
	// encodings
	//////////////////////////////

	// issue port opcodes
	typedef enum logic[2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_XOR = 3'd3,
		OP_MUL = 3'd4
	} op_t;

	// owner of a result bus slot
	typedef enum logic {
		UNIT_ALU = 1'b0,
		UNIT_MUL = 1'b1
	} unit_t;

endpackage

// File: hw/tag_allocator.sv
module tag_allocator import result_bus_pkg::*; #(
	parameter int TAG_WIDTH = DEFAULT_TAG_WIDTH
) (
	input logic clk,
	input logic rst,
	input logic alloc,
	input logic retire,
	output logic[TAG_WIDTH-1:0] next_tag,
	output logic tag_free,
	output logic idle
);
	// one extra bit so a full set of 2^TAG_WIDTH fits
	logic[TAG_WIDTH:0] in_flight;

	//////////////////////////////
	// tag counter
	//////////////////////////////

	// tags go out in order and wrap
	always_ff @(posedge clk) begin
		if (rst) begin
			next_tag <= '0;
		end else if (alloc) begin
			next_tag <= next_tag + 1'b1;
		end
	end

	//////////////////////////////
	// results in flight
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			in_flight <= '0;
		end else begin
			case ({alloc, retire})
				2'b10: in_flight <= in_flight + 1'b1;
				2'b01: in_flight <= in_flight - 1'b1;
				default: in_flight <= in_flight;
			endcase
		end
	end

	// msb set only when every tag is outstanding
	assign tag_free = !in_flight[TAG_WIDTH];
	assign idle = in_flight == '0;
endmodule

// File: sim.f
hw/result_bus_pkg.sv
hw/int_alu.sv
hw/int_mul.sv
hw/bus_reservation.sv
hw/tag_allocator.sv
hw/result_bus_core.sv
verification/result_bus_checker.sv
verification/result_bus_core_tb.sv

// File: verification/result_bus_checker.sv
module result_bus_checker import result_bus_pkg::*; (
	input logic clk,
	input logic rst,
	input logic issue_valid,
	input op_t issue_op,
	input logic issue_ready,
	input logic tag_free,
	input logic cdb_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	unit_t issue_unit;

	// unit that would take the op at the issue port
	assign issue_unit = issue_op == OP_MUL ? UNIT_MUL : UNIT_ALU;

	// bus is quiet right after reset
	reset_quiet: assert property (@(posedge clk) rst |=> !cdb_valid)
		else $error("result bus valid in the cycle after reset");

	// no issue with every tag outstanding
	ready_needs_tag: assert property (@(posedge clk) disable iff (rst)
		!(issue_ready && !tag_free))
		else $error("issue_ready high while no tag is free");

	// alu result goes out on the very next cycle
	alu_next_cycle: assert property (@(posedge clk) disable iff (rst)
		(issue_valid && issue_ready && issue_unit == UNIT_ALU) |=> cdb_valid)
		else $error("accepted alu op missing from the bus on the next cycle");
endmodule

bind result_bus_core result_bus_checker u_checker (
	.clk,
	.rst,
	.issue_valid,
	.issue_op,
	.issue_ready,
	.tag_free,
	.cdb_valid
);

// File: verification/result_bus_core_tb.sv
module result_bus_core_tb import result_bus_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DATA_WIDTH = DEFAULT_DATA_WIDTH;
	localparam int TAG_WIDTH = DEFAULT_TAG_WIDTH;
	localparam int MUL_LATENCY = DEFAULT_MUL_LATENCY;
	localparam int NUM_TAGS = 2 ** TAG_WIDTH;

	localparam int IDLE_CYCLES = 6;
	localparam int N_ALU = 16;
	localparam int N_WRAP = NUM_TAGS + 3;
	localparam int N_RANDOM = 200;
	localparam int DRAIN_CYCLES = MUL_LATENCY + 4;

	// worst case cycles of all tests summed
	localparam int CYCLE_BUDGET = 4 + IDLE_CYCLES + N_ALU + NUM_TAGS + 2 * MUL_LATENCY
		+ N_WRAP * (MUL_LATENCY + 1) + N_RANDOM * (MUL_LATENCY + 2) + 6 * DRAIN_CYCLES;
	localparam int TIMEOUT_NS = CYCLE_BUDGET * 10 + 500;

	typedef logic[DATA_WIDTH-1:0] data_t;
	typedef logic[TAG_WIDTH-1:0] tag_t;

	logic clk = 1'b0;
	logic rst;
	logic issue_valid;
	op_t issue_op;
	data_t issue_a;
	data_t issue_b;
	logic issue_ready;
	tag_t issue_tag;
	logic cdb_valid;
	tag_t cdb_tag;
	data_t cdb_data;
	logic idle;

	// scoreboard indexed by tag
	logic pending[NUM_TAGS];
	op_t exp_op[NUM_TAGS];
	data_t exp_data[NUM_TAGS];
	int accept_cycle[NUM_TAGS];
	tag_t retired[$];

	tag_t next_tag_model = '0;
	int cycle = 0;
	logic[31:0] lfsr_state = 32'h32f1;

	result_bus_core #(
		.DATA_WIDTH(DATA_WIDTH),
		.TAG_WIDTH(TAG_WIDTH),
		.MUL_LATENCY(MUL_LATENCY)
	) UUT (
		.clk,
		.rst,
		.issue_valid,
		.issue_op,
		.issue_a,
		.issue_b,
		.issue_ready,
		.issue_tag,
		.cdb_valid,
		.cdb_tag,
		.cdb_data,
		.idle
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	// taps 32 22 2 1
	function automatic logic[31:0] lfsr_next(input logic[31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic data_t random_bits(input int n);
		data_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[DATA_WIDTH-2:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic data_t expected_result(input op_t op, input data_t a, input data_t b);
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_XOR: return a ^ b;
			default: return a * b;
		endcase
	endfunction

	task automatic stop_on_failure();
		$display("Test failures found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_data(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_tag(input tag_t got, input tag_t exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s, got %0d expected %0d", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s, got %b expected %b", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic compare_latency(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("[FAIL] %0t: %s, got %0d cycles expected %0d", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic send_op(input op_t op, input data_t a, input data_t b,
			output tag_t tag, output int stalls);
		issue_valid = 1'b1;
		issue_op = op;
		issue_a = a;
		issue_b = b;
		stalls = 0;
		#1;
		while (!issue_ready) begin
			stalls++;
			@(negedge clk);
			#1;
		end
		tag = issue_tag;
		check_tag(tag, next_tag_model, "issue tag order");
		check_bit(pending[tag], 1'b0, "issued tag still in flight");
		pending[tag] = 1'b1;
		exp_op[tag] = op;
		exp_data[tag] = expected_result(op, a, b);
		// rising edges counted before the accepting one
		accept_cycle[tag] = cycle;
		next_tag_model++;
		@(negedge clk);
		issue_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (!idle && n < DRAIN_CYCLES) begin
			@(negedge clk);
			n++;
		end
		check_bit(idle, 1'b1, "idle after the results drained");
	endtask

	//////////////////////////////
	// bus monitor
	//////////////////////////////

	always @(negedge clk) begin : bus_monitor
		tag_t t;
		if (!rst && cdb_valid) begin
			t = cdb_tag;
			check_bit(pending[t], 1'b1, "result for a tag in flight");
			check_data(cdb_data, exp_data[t], "result data");
			compare_latency(cycle - accept_cycle[t], exp_op[t] == OP_MUL ? MUL_LATENCY : 1,
				"result latency");
			pending[t] = 1'b0;
			retired.push_back(t);
		end
	end

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic idle_after_reset();
		check_tag(issue_tag, '0, "first tag after reset");
		repeat (IDLE_CYCLES) begin
			check_bit(issue_ready, 1'b1, "issue_ready after reset");
			check_bit(idle, 1'b1, "idle after reset");
			check_bit(cdb_valid, 1'b0, "cdb_valid after reset");
			@(negedge clk);
		end
	endtask

	task automatic alu_ops();
		data_t a;
		data_t b;
		tag_t tag;
		int stalls;
		for (int i = 0; i < N_ALU; i++) begin
			a = random_bits(DATA_WIDTH);
			b = random_bits(DATA_WIDTH);
			send_op(op_t'(i % 4), a, b, tag, stalls);
			check_bit(stalls == 0, 1'b1, "alu op accepted without stall");
		end
		wait_drain();
	endtask

	task automatic mul_stream();
		data_t a;
		data_t b;
		tag_t tag;
		tag_t issued[$];
		int stalls;
		retired.delete();
		for (int i = 0; i < NUM_TAGS; i++) begin
			a = random_bits(DATA_WIDTH);
			b = random_bits(DATA_WIDTH);
			send_op(OP_MUL, a, b, tag, stalls);
			check_bit(stalls == 0, 1'b1, "multiply accepted back to back");
			issued.push_back(tag);
		end
		wait_drain();
		check_bit(retired.size() == NUM_TAGS, 1'b1, "every multiply retired");
		foreach (issued[i]) begin
			check_tag(retired[i], issued[i], "multiply results in issue order");
		end
	endtask

	task automatic collision_stall();
		data_t a;
		data_t b;
		tag_t mul_tag;
		tag_t alu_tag;
		int stalls;
		retired.delete();
		a = random_bits(DATA_WIDTH);
		b = random_bits(DATA_WIDTH);
		send_op(OP_MUL, a, b, mul_tag, stalls);
		// next issue lands the alu result in the booked slot
		repeat (MUL_LATENCY - 2) @(negedge clk);
		a = random_bits(DATA_WIDTH);
		b = random_bits(DATA_WIDTH);
		send_op(OP_XOR, a, b, alu_tag, stalls);
		check_bit(stalls == 1, 1'b1, "alu op held back for one cycle");
		wait_drain();
		check_bit(retired.size() == 2, 1'b1, "both results retired");
		check_tag(retired[0], mul_tag, "multiply result first");
		check_tag(retired[1], alu_tag, "alu result second");
	endtask

	task automatic tag_wraparound();
		data_t a;
		data_t b;
		tag_t tag;
		int stalls;
		int total_stalls;
		total_stalls = 0;
		for (int i = 0; i < N_WRAP; i++) begin
			a = random_bits(DATA_WIDTH);
			b = random_bits(DATA_WIDTH);
			send_op(OP_MUL, a, b, tag, stalls);
			total_stalls += stalls;
		end
		check_bit(total_stalls > 0, 1'b1, "issue_ready dropped with all tags in use");
		wait_drain();
	endtask

	task automatic random_mix();
		data_t a;
		data_t b;
		op_t op;
		tag_t tag;
		int stalls;
		retired.delete();
		for (int i = 0; i < N_RANDOM; i++) begin
			op = op_t'(random_bits(3) % 5);
			a = random_bits(DATA_WIDTH);
			b = random_bits(DATA_WIDTH);
			send_op(op, a, b, tag, stalls);
			if (random_bits(2) == 0) begin
				@(negedge clk);
			end
		end
		wait_drain();
		check_bit(retired.size() == N_RANDOM, 1'b1, "every random op retired once");
		for (int t = 0; t < NUM_TAGS; t++) begin
			check_bit(pending[t], 1'b0, "no tag left in flight");
		end
	endtask

	//////////////////////////////
	// main
	//////////////////////////////

	initial begin
		rst = 1'b1;
		issue_valid = 1'b0;
		issue_op = OP_ADD;
		issue_a = '0;
		issue_b = '0;
		for (int t = 0; t < NUM_TAGS; t++) begin
			pending[t] = 1'b0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		idle_after_reset();
		alu_ops();
		mul_stream();
		collision_stall();
		tag_wraparound();
		random_mix();
		$display("All tests passed!");
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		stop_on_failure();
	end
endmodule
